//--- vlog.f
hdl/uart_pkg.sv
hdl/fir_pkg.sv
hdl/uart_rx.sv
hdl/sample_decoder.sv
hdl/fir_filter.sv
hdl/result_serializer.sv
hdl/uart_tx.sv
hdl/uart_fir_top.sv
bench/tb_uart_fir.sv

//--- Makefile
# Verilator flow for the UART FIR project

VERILATOR ?= verilator
TOP       ?= tb_uart_fir
RTL_TOP   ?= uart_fir_top
FILELIST  ?= vlog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= SIMULATION PASSED
FLAGS     ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_uart_fir.sv
module tb_uart_fir;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT  = 16;
    localparam int OVERSAMPLING  = 4;
    localparam int NUM_FIXED     = 20;
    localparam int NUM_VECTORS   = 48;                  // Long enough for the tx backlog to fill the pending slot
    localparam int START_TIMEOUT = 40 * CLKS_PER_BIT;   // Clocks to wait for a tx start bit

    // Impulse, step, then full-scale and negative extremes
    localparam logic signed [15:0] FIXED [NUM_FIXED] = '{
        16'sd256, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0,
        16'sd1000, 16'sd1000, 16'sd1000, 16'sd1000, 16'sd1000, 16'sd1000,
        16'sh8000, 16'sh7fff, 16'sh7fff, 16'sh8000, 16'sh8000, 16'shffff};

    typedef struct packed {
        fir_pkg::sample_t stim;                    // Sample sent on uart_rxd
        fir_pkg::result_t exp;                     // Model output for it
    } vector_t;

    logic    clk;
    logic    arst_n;
    logic    uart_rxd;
    logic    uart_txd;
    vector_t vectors [NUM_VECTORS];

    uart_fir_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .OVERSAMPLING (OVERSAMPLING)
    ) u_uart_fir_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                     // 4 ns period
    end

    //////////////////////////////
    // Failure and compare tasks
    //////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_byte(input string name, input uart_pkg::uart_byte_t got,
                              input uart_pkg::uart_byte_t exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_result(input string name, input fir_pkg::result_t got,
                                input fir_pkg::result_t exp);
        if (got !== exp)
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    //////////////////////////////
    // Stimulus and model
    //////////////////////////////
    task automatic fill_vectors;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (i < NUM_FIXED)
                vectors[i].stim.word = FIXED[i];
            else
                vectors[i].stim.word = 16'($urandom());   // Random tail
        end
    endtask

    // Software delay line, window of bits RESULT_LSB+15 down to RESULT_LSB
    task automatic build_expected;
        longint hist [fir_pkg::NUM_TAPS];
        longint acc;
        for (int t = 0; t < fir_pkg::NUM_TAPS; t++)
            hist[t] = 0;                           // Silence before the run
        for (int i = 0; i < NUM_VECTORS; i++) begin
            for (int t = fir_pkg::NUM_TAPS - 1; t > 0; t--)
                hist[t] = hist[t-1];
            hist[0] = longint'(vectors[i].stim.word);
            acc = 0;
            for (int t = 0; t < fir_pkg::NUM_TAPS; t++)
                acc += hist[t] * longint'(fir_pkg::COEFFS[t]);
            vectors[i].exp = fir_pkg::result_t'(acc >>> fir_pkg::RESULT_LSB);   // Wraps on overflow
        end
    endtask

    //////////////////////////////
    // Serial driver and monitor
    //////////////////////////////
    task automatic send_frame(input uart_pkg::uart_byte_t data);
        logic [uart_pkg::FRAME_BITS-1:0] frame;
        frame = {uart_pkg::STOP_BIT, data, uart_pkg::START_BIT};   // LSB goes first
        for (int b = 0; b < uart_pkg::FRAME_BITS; b++) begin
            @(posedge clk);
            uart_rxd <= frame[b];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic drive_samples;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            send_frame(vectors[i].stim.bytes.lo);  // Back to back, no gap
            send_frame(vectors[i].stim.bytes.hi);
        end
    endtask

    task automatic recv_frame(output uart_pkg::uart_byte_t data);
        int waited;
        waited = 0;
        while (uart_txd !== uart_pkg::START_BIT) begin
            @(posedge clk);
            waited++;
            if (waited > START_TIMEOUT)
                abort_run("Timed out waiting for a start bit on uart_txd");
        end
        repeat (CLKS_PER_BIT / 2) @(posedge clk);  // Middle of the start bit
        if (uart_txd !== uart_pkg::START_BIT)
            abort_run("Start bit on uart_txd did not last half a bit period");
        for (int b = 0; b < uart_pkg::DATA_BITS; b++) begin
            repeat (CLKS_PER_BIT) @(posedge clk);
            data[b] = uart_txd;
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        if (uart_txd !== uart_pkg::STOP_BIT)
            abort_run("Framing error, the stop bit on uart_txd was low");
    endtask

    task automatic collect_results;
        uart_pkg::uart_byte_t lo;
        uart_pkg::uart_byte_t hi;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            recv_frame(lo);
            check_byte($sformatf("uart_txd low byte %0d", i), lo, vectors[i].exp[7:0]);
            recv_frame(hi);
            check_result($sformatf("result %0d", i), {hi, lo}, vectors[i].exp);
        end
    endtask

    // Line must rest high, a frame here is unexpected
    task automatic expect_line_idle(input int bits);
        repeat (bits * CLKS_PER_BIT) begin
            @(posedge clk);
            if (uart_txd !== uart_pkg::IDLE_LEVEL)
                abort_run("uart_txd left the idle level while no frame was due");
        end
    endtask

    //////////////////////////////
    // Run
    //////////////////////////////
    initial begin
        arst_n   = 1'b0;
        uart_rxd = uart_pkg::IDLE_LEVEL;
        void'($urandom(15));                       // Fixed seed
        fill_vectors();
        build_expected();
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        expect_line_idle(30);                      // Quiet output before input
        fork
            drive_samples();
            collect_results();
        join
        expect_line_idle(30);                      // No extra frames
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- hdl/uart_fir_top.sv
module uart_fir_top #(
    parameter int CLKS_PER_BIT = 16,               // Serial bit period in clocks
    parameter int OVERSAMPLING = 4                 // Receiver ticks per bit
) (
    input  logic clk,
    input  logic arst_n,
    input  logic uart_rxd,                         // Samples in
    output logic uart_txd                          // Results out
);

    uart_pkg::rx_byte_t   rx_byte;
    fir_pkg::sample_t     sample;
    logic                 sample_valid;
    fir_pkg::result_t     result;
    logic                 result_valid;
    uart_pkg::uart_byte_t tx_data;
    logic                 tx_start;
    logic                 tx_busy;

    //////////////////////////////
    // Decode
    //////////////////////////////
    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .OVERSAMPLING (OVERSAMPLING)
    ) u_uart_rx (
        .clk     (clk),
        .arst_n  (arst_n),
        .rxd     (uart_rxd),
        .rx_byte (rx_byte)
    );

    sample_decoder u_sample_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .rx_byte      (rx_byte),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    //////////////////////////////
    // Execute
    //////////////////////////////
    fir_filter u_fir_filter (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    //////////////////////////////
    // Result
    //////////////////////////////
    result_serializer u_result_serializer (
        .clk          (clk),
        .arst_n       (arst_n),
        .result       (result),
        .result_valid (result_valid),
        .tx_busy      (tx_busy),
        .tx_data      (tx_data),
        .tx_start     (tx_start)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (uart_txd),
        .tx_busy  (tx_busy)
    );

endmodule

//--- hdl/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 16                // Clocks per serial bit
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 tx_start,         // Send one frame
    input  uart_pkg::uart_byte_t tx_data,          // Byte to send
    output logic                 txd,              // Serial line
    output logic                 tx_busy           // High for the whole frame
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);
    localparam int FW = $clog2(uart_pkg::FRAME_BITS);

    localparam logic [CW-1:0] CLK_LAST   = CW'(CLKS_PER_BIT - 1);
    localparam logic [FW-1:0] FRAME_LAST = FW'(uart_pkg::FRAME_BITS - 1);

    logic [CW-1:0]                 clk_cnt;        // Clocks within the bit
    logic [FW-1:0]                 bit_cnt;        // 0 start, 1..8 data, 9 stop
    logic [uart_pkg::DATA_BITS:0]  shift_reg;      // Stop bit above the data

    //////////////////////////////
    // Bit timing
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            txd     <= uart_pkg::IDLE_LEVEL;
            tx_busy <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                txd     <= uart_pkg::START_BIT;    // Line drops next cycle
                tx_busy <= 1'b1;
                clk_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (clk_cnt == CLK_LAST) begin
            clk_cnt <= '0;
            if (bit_cnt == FRAME_LAST) begin
                tx_busy <= 1'b0;                   // End of stop bit
            end else begin
                txd     <= shift_reg[0];           // Next bit, LSB first
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Frame body, latched on start
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start)
            shift_reg <= {uart_pkg::STOP_BIT, tx_data};
        else if (tx_busy && clk_cnt == CLK_LAST)
            shift_reg <= shift_reg >> 1;
    end

    // Serializer must wait out the busy level
    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy);

endmodule

//--- hdl/result_serializer.sv
module result_serializer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  fir_pkg::result_t     result,           // From the filter
    input  logic                 result_valid,     // One-cycle strobe
    input  logic                 tx_busy,          // Transmitter level
    output uart_pkg::uart_byte_t tx_data,          // Byte for the transmitter
    output logic                 tx_start          // One-cycle start strobe
);

    fir_pkg::result_t cur_word;                    // Result being sent
    fir_pkg::result_t pend_word;                   // Result waiting
    fir_pkg::result_t send_word;
    logic             cur_valid;
    logic             pend_valid;
    logic             hi_next;                     // High byte goes out next
    logic             start_now;
    logic             free_slot;                   // Current result done

    // Idle path sends straight from the input
    assign send_word = cur_valid ? cur_word : result;
    // Skip the cycle of our own strobe, busy shows one later
    assign start_now = !tx_busy && !tx_start && (cur_valid || result_valid);
    assign free_slot = start_now && hi_next;

    //////////////////////////////
    // Slot control
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_valid  <= 1'b0;
            pend_valid <= 1'b0;
            hi_next    <= 1'b0;                    // Low byte first
            tx_start   <= 1'b0;
        end else begin
            tx_start <= start_now;
            if (start_now)
                hi_next <= !hi_next;
            if (free_slot) begin
                cur_valid  <= pend_valid || result_valid;   // Pending moves up
                pend_valid <= pend_valid && result_valid;
            end else if (result_valid) begin
                if (cur_valid)
                    pend_valid <= 1'b1;
                else
                    cur_valid  <= 1'b1;
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (start_now)
            tx_data <= hi_next ? send_word[15:8] : send_word[7:0];
        if (free_slot) begin
            cur_word <= pend_valid ? pend_word : result;
            if (result_valid)
                pend_word <= result;
        end else if (result_valid) begin
            if (cur_valid)
                pend_word <= result;
            else
                cur_word  <= result;
        end
    end

    // Overflow means the output baud cannot keep up with the input
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid && cur_valid && pend_valid |-> free_slot);

endmodule

//--- hdl/fir_filter.sv
module fir_filter (
    input  logic             clk,
    input  logic             arst_n,
    input  fir_pkg::sample_t sample,               // New input word
    input  logic             sample_valid,         // One-cycle strobe
    output fir_pkg::result_t result,               // Scaled output
    output logic             result_valid          // Follows sample_valid by one
);

    localparam int NT = fir_pkg::NUM_TAPS;

    // Registered history, newest first
    logic signed [15:0] taps   [NT-1];
    // Incoming sample plus history, eight in flight
    logic signed [15:0] window [NT];
    fir_pkg::acc_t      acc;                       // Full-width sum

    //////////////////////////////
    // Multiply-accumulate
    //////////////////////////////
    always_comb begin
        window[0] = sample.word;                   // Signed view of the union
        for (int i = 1; i < NT; i++)
            window[i] = taps[i-1];
    end

    always_comb begin
        acc = '0;
        for (int i = 0; i < NT; i++)
            acc += fir_pkg::acc_t'(window[i]) * fir_pkg::acc_t'(fir_pkg::COEFFS[i]);
    end

    //////////////////////////////
    // Delay line and output
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NT - 1; i++)
                taps[i] <= '0;                     // Start from silence
            result_valid <= 1'b0;
        end else begin
            result_valid <= sample_valid;
            if (sample_valid) begin
                for (int i = 0; i < NT - 1; i++)
                    taps[i] <= window[i];          // Shift by one position
            end
        end
    end

    // Fixed window of the accumulator, upper bits dropped
    always_ff @(posedge clk) begin
        if (sample_valid)
            result <= acc[fir_pkg::RESULT_LSB +: $bits(fir_pkg::result_t)];
    end

    // Single-cycle latency through the MAC
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid == $past(sample_valid));

endmodule

//--- hdl/sample_decoder.sv
module sample_decoder (
    input  logic               clk,
    input  logic               arst_n,
    input  uart_pkg::rx_byte_t rx_byte,            // Byte stream from the receiver
    output fir_pkg::sample_t   sample,             // Assembled sample
    output logic               sample_valid        // One cycle per pair
);

    logic hi_phase;                                // Next byte is the high byte

    //////////////////////////////
    // Pair tracking
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi_phase     <= 1'b0;                  // Expect low byte first
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= rx_byte.valid && hi_phase;   // Pair complete
            if (rx_byte.valid)
                hi_phase <= !hi_phase;
        end
    end

    // Byte view of the union filled one half at a time
    always_ff @(posedge clk) begin
        if (rx_byte.valid) begin
            if (hi_phase)
                sample.bytes.hi <= rx_byte.data;   // Second byte
            else
                sample.bytes.lo <= rx_byte.data;   // First byte
        end
    end

endmodule

//--- hdl/uart_rx.sv
module uart_rx #(
    parameter int CLKS_PER_BIT = 16,               // Clocks per serial bit
    parameter int OVERSAMPLING = 4                 // Ticks per serial bit
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rxd,                // Async serial line
    output uart_pkg::rx_byte_t rx_byte             // Byte plus one-cycle strobe
);

    localparam int TICK_DIV = CLKS_PER_BIT / OVERSAMPLING;   // Clocks per tick
    localparam int TW       = $clog2(TICK_DIV + 1);
    localparam int OW       = $clog2(OVERSAMPLING + 1);
    localparam int BW       = $clog2(uart_pkg::DATA_BITS);

    localparam logic [TW-1:0] TICK_LAST = TW'(TICK_DIV - 1);
    localparam logic [OW-1:0] OVS_LAST  = OW'(OVERSAMPLING - 1);      // Full bit
    localparam logic [OW-1:0] HALF_LAST = OW'(OVERSAMPLING / 2 - 1);  // Half bit
    localparam logic [BW-1:0] BIT_LAST  = BW'(uart_pkg::DATA_BITS - 1);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t                 state;
    logic [2:0]             rxd_sync;              // [1:0] synchronizer, [2] edge history
    logic                   rxd_s;                 // Synchronized line
    logic                   fall;                  // Falling edge on the line
    logic [TW-1:0]          tick_cnt;
    logic                   tick;                  // One oversampling tick
    logic [OW-1:0]          ovs_cnt;               // Ticks within the bit
    logic [BW-1:0]          bit_cnt;               // Data bit index
    uart_pkg::uart_byte_t   shift_reg;             // Data shifted in LSB first
    logic                   rx_valid;

    assign rxd_s = rxd_sync[1];
    assign fall  = rxd_sync[2] & ~rxd_sync[1];     // High then low
    assign tick  = (tick_cnt == TICK_LAST);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_sync <= {3{uart_pkg::IDLE_LEVEL}};
            state    <= S_IDLE;
            tick_cnt <= '0;
            ovs_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};      // Two-flop sync plus history
            rx_valid <= 1'b0;                      // Strobe by default low

            if (state == S_IDLE || tick)
                tick_cnt <= '0;                    // Restart the tick phase
            else
                tick_cnt <= tick_cnt + 1'b1;

            case (state)
                S_IDLE: begin
                    ovs_cnt <= '0;
                    if (fall)
                        state <= S_START;          // Start bit begins
                end
                S_START: if (tick) begin
                    if (ovs_cnt == HALF_LAST) begin
                        ovs_cnt <= '0;
                        bit_cnt <= '0;
                        // Glitch shorter than half a bit returns to idle
                        state   <= (rxd_s == uart_pkg::START_BIT) ? S_DATA : S_IDLE;
                    end else begin
                        ovs_cnt <= ovs_cnt + 1'b1;
                    end
                end
                S_DATA: if (tick) begin
                    if (ovs_cnt == OVS_LAST) begin
                        ovs_cnt <= '0;
                        if (bit_cnt == BIT_LAST)
                            state <= S_STOP;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        ovs_cnt <= ovs_cnt + 1'b1;
                    end
                end
                S_STOP: if (tick) begin
                    if (ovs_cnt == OVS_LAST) begin
                        rx_valid <= (rxd_s == uart_pkg::STOP_BIT);   // Framing check
                        state    <= S_IDLE;
                    end else begin
                        ovs_cnt <= ovs_cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Data capture at mid bit, no reset on payload
    always_ff @(posedge clk) begin
        if (state == S_DATA && tick && ovs_cnt == OVS_LAST)
            shift_reg <= {rxd_s, shift_reg[uart_pkg::DATA_BITS-1:1]};  // LSB first
    end

    assign rx_byte.valid = rx_valid;
    assign rx_byte.data  = shift_reg;

    if (CLKS_PER_BIT % OVERSAMPLING != 0 || OVERSAMPLING < 2) begin : g_bad_ovs
        $error("CLKS_PER_BIT must be a multiple of OVERSAMPLING, OVERSAMPLING >= 2");
    end

    // Frames last ten bits, so strobes never touch
    a_single_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        rx_valid |=> !rx_valid);

endmodule

//--- hdl/fir_pkg.sv
package fir_pkg;

    //////////////////////////////
    // Sample word
    //////////////////////////////
    typedef struct packed {
        logic [7:0] hi;                            // Second byte on the line
        logic [7:0] lo;                            // First byte on the line
    } sample_bytes_t;

    // Byte view while assembling, signed view while filtering
    typedef union packed {
        sample_bytes_t      bytes;                 // Assembly view
        logic signed [15:0] word;                  // Arithmetic view
    } sample_t;

    typedef logic signed [15:0] result_t;          // Scaled filter output
    typedef logic signed [37:0] acc_t;             // Full-width MAC sum
    typedef logic signed [7:0]  coeff_t;           // One tap weight

    //////////////////////////////
    // Filter constants
    //////////////////////////////
    localparam int NUM_TAPS = 8;                   // Delay line depth

    // Symmetric low-pass weights, tap 0 first
    localparam coeff_t COEFFS [NUM_TAPS] = '{8'sd16, 8'sd32, 8'sd48, 8'sd64,
                                             8'sd64, 8'sd48, 8'sd32, 8'sd16};

    localparam int RESULT_LSB = 8;                 // Bottom of the output window

endpackage

//--- hdl/uart_pkg.sv
package uart_pkg;

    //////////////////////////////
    // Framing
    //////////////////////////////
    localparam int DATA_BITS  = 8;                 // Payload bits per frame
    localparam int FRAME_BITS = DATA_BITS + 2;     // Start + data + stop

    localparam logic START_BIT  = 1'b0;            // Line level of the start bit
    localparam logic STOP_BIT   = 1'b1;            // Line level of the stop bit
    localparam logic IDLE_LEVEL = 1'b1;            // Line rests high between frames

    //////////////////////////////
    // Types
    //////////////////////////////
    typedef logic [DATA_BITS-1:0] uart_byte_t;     // One serial byte

    // Receiver output, valid strobes for a single cycle per good frame
    typedef struct packed {
        logic       valid;                         // One cycle per frame
        uart_byte_t data;                          // Received byte, LSB first on the line
    } rx_byte_t;

endpackage
